/* src/okiPkg.sv */
// ============================================================
// OKI ADPCM sound generator shared definitions
// widths, state enums and the decoder constant tables
// ============================================================

package okiPkg;

	localparam int NUM_VOICES = 4;

	typedef logic [1:0]          voiceId_t;
	typedef logic [17:0]         romAddr_t;
	typedef logic [7:0]          romByte_t;
	typedef logic [3:0]          nibble_t;   // bit 3 sign, 2..0 magnitude
	typedef logic [6:0]          phrase_t;
	typedef logic [3:0]          atten_t;
	typedef logic signed [11:0]  signal_t;
	typedef logic [5:0]          stepIdx_t;
	typedef logic signed [17:0]  sample_t;
	typedef logic signed [19:0]  mix_t;

	// phrase table entry is 3 bytes start, 3 bytes end, 2 spare
	localparam int HDR_BYTES = 8;
	localparam romAddr_t DATA_START = 18'h400;

	localparam int SIG_MAX = 2047;
	localparam int SIG_MIN = -2048;
	localparam int STEP_MAX = 48;

	// sample period is reload value plus one
	localparam logic [9:0] RATE_SLOW = 10'd492;
	localparam logic [9:0] RATE_FAST = 10'd393;

	// standard OKI step sizes
	localparam logic [10:0] STEP_SIZE [0:48] = '{
		16, 17, 19, 21, 23, 25, 28, 31, 34, 37,
		41, 45, 50, 55, 60, 66, 73, 80, 88, 97,
		107, 118, 130, 143, 157, 173, 190, 209, 230, 253,
		279, 307, 337, 371, 408, 449, 494, 544, 598, 658,
		724, 796, 876, 963, 1060, 1166, 1282, 1411, 1552
	};

	// index change per magnitude
	localparam logic signed [4:0] STEP_ADJUST [0:7] = '{
		-5'sd1, -5'sd1, -5'sd1, -5'sd1, 5'sd2, 5'sd4, 5'sd6, 5'sd8
	};

	// roughly 3 dB per attenuation code, silent from 9 up
	localparam logic [5:0] VOLUME [0:15] = '{
		32, 22, 16, 11, 8, 6, 4, 3, 2, 0, 0, 0, 0, 0, 0, 0
	};

	typedef enum logic {
		CMD_FIRST,
		CMD_SECOND
	} cmdState_t;

	typedef enum logic [2:0] {
		SEQ_WAIT,
		SEQ_SLOT,
		SEQ_HDR,
		SEQ_ADDR,
		SEQ_READ,
		SEQ_NEXT
	} seqState_t;

endpackage

/* src/cmdIf.sv */
// ============================================================
// decoded voice commands, command decoder to sequencer
// ============================================================

`timescale 1ns/1ps

interface cmdIf import okiPkg::*; ();

	logic                  startValid;   // single cycle
	voiceId_t              startVoice;
	phrase_t               startPhrase;
	atten_t                startAtten;
	logic [NUM_VOICES-1:0] stopMask;     // single cycle, one bit per voice

	modport source (output startValid, startVoice, startPhrase, startAtten, stopMask);
	modport sink (input startValid, startVoice, startPhrase, startAtten, stopMask);

endinterface

/* src/nibbleIf.sv */
// ============================================================
// one ADPCM nibble per voice slot, sequencer to decoder
// ============================================================

`timescale 1ns/1ps

interface nibbleIf import okiPkg::*; ();

	logic     valid;
	voiceId_t voice;
	nibble_t  nibble;
	logic     restart;   // first nibble of a phrase

	modport source (output valid, voice, nibble, restart);
	modport sink (input valid, voice, nibble, restart);

endinterface

/* src/cmdDecoder.sv */
// ============================================================
// CPU command port
// catches write strobe edges and decodes the one-byte stop
// and two-byte start commands
// ============================================================

`timescale 1ns/1ps

module cmdDecoder import okiPkg::*; (
	input  logic     CLK,
	input  logic     RESET_N,
	input  logic     chipSelN,
	input  logic     writeN,
	input  romByte_t dataIn,
	cmdIf.source     cmd
);

	logic      wrPrev;
	logic      csPrev;
	romByte_t  dataPrev;
	logic      wrEdge;
	cmdState_t state;
	phrase_t   phrase;

	// write acts once, on the rising edge of writeN
	assign wrEdge = writeN && !wrPrev && !csPrev;

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			wrPrev   <= 1'b1;
			csPrev   <= 1'b1;
			dataPrev <= '0;
			state    <= CMD_FIRST;
		end else begin
			wrPrev   <= writeN;
			csPrev   <= chipSelN;
			dataPrev <= dataIn;
			if (wrEdge) begin
				if (state == CMD_FIRST) begin
					if (dataPrev[7])
						state <= CMD_SECOND;   // phrase byte, wait for voice byte
				end else begin
					state <= CMD_FIRST;
				end
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (wrEdge && state == CMD_FIRST && dataPrev[7])
			phrase <= dataPrev[6:0];
	end

	always_comb begin
		cmd.startValid  = wrEdge && (state == CMD_SECOND) && (|dataPrev[7:4]);
		cmd.startPhrase = phrase;
		cmd.startAtten  = dataPrev[3:0];
		// only one channel per command, lowest wins
		if (dataPrev[4])
			cmd.startVoice = 2'd0;
		else if (dataPrev[5])
			cmd.startVoice = 2'd1;
		else if (dataPrev[6])
			cmd.startVoice = 2'd2;
		else
			cmd.startVoice = 2'd3;
		if (wrEdge && state == CMD_FIRST && !dataPrev[7])
			cmd.stopMask = dataPrev[6:3];
		else
			cmd.stopMask = '0;
	end

endmodule

/* src/voiceSequencer.sv */
// ============================================================
// voice sequencer
// holds the gates, fetches phrase headers and reads one
// nibble per gated voice in each sample round
// ============================================================

`timescale 1ns/1ps

module voiceSequencer import okiPkg::*; (
	input  logic                  CLK,
	input  logic                  RESET_N,
	cmdIf.sink                    cmd,
	input  logic                  sampleTick,
	output romAddr_t              romAddr,
	input  romByte_t              romData,
	nibbleIf.source               nib,
	output logic [NUM_VOICES-1:0] gates,
	output atten_t                atten [NUM_VOICES]
);

	seqState_t             state;
	voiceId_t              slot;
	logic [2:0]            hdrCnt;
	logic [NUM_VOICES-1:0] gate;
	logic [NUM_VOICES-1:0] pending;   // started, waiting for the next round
	logic [NUM_VOICES-1:0] fetch;     // admitted, header not read yet
	phrase_t               phrase [NUM_VOICES];
	romAddr_t              startAddr [NUM_VOICES];
	romAddr_t              endAddr [NUM_VOICES];
	logic [18:0]           nibIdx [NUM_VOICES];   // byte address plus nibble select
	romAddr_t              byteAddr;
	romAddr_t              hdrBase;
	logic                  slotLive;
	logic                  inRange;

	assign gates    = gate;
	assign slotLive = gate[slot] && !pending[slot];
	assign hdrBase  = romAddr_t'(phrase[slot] * HDR_BYTES);
	assign byteAddr = nibIdx[slot][18:1];
	assign inRange  = (byteAddr >= DATA_START) && (byteAddr >= startAddr[slot])
		&& (byteAddr <= endAddr[slot]);

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			state       <= SEQ_WAIT;
			slot        <= '0;
			hdrCnt      <= '0;
			romAddr     <= '0;
			gate        <= '0;
			pending     <= '0;
			fetch       <= '0;
			nib.valid   <= 1'b0;
			nib.voice   <= '0;
			nib.nibble  <= '0;
			nib.restart <= 1'b0;
			for (int v = 0; v < NUM_VOICES; v++)
				nibIdx[v] <= '0;
		end else begin
			nib.valid <= 1'b0;
			case (state)
				SEQ_WAIT: begin
					if (sampleTick) begin
						fetch   <= fetch | pending;   // admit started voices
						pending <= '0;
						slot    <= '0;
						state   <= SEQ_SLOT;
					end
				end
				SEQ_SLOT: begin
					if (!slotLive) begin
						state <= SEQ_NEXT;
					end else if (fetch[slot]) begin
						romAddr <= hdrBase;
						hdrCnt  <= '0;
						state   <= SEQ_HDR;
					end else begin
						romAddr <= byteAddr;
						state   <= SEQ_ADDR;
					end
				end
				SEQ_HDR: begin
					// one address per cycle, data trails by one
					romAddr <= romAddr + 1'b1;
					hdrCnt  <= hdrCnt + 1'b1;
					if (hdrCnt == 3'd6) begin
						romAddr      <= startAddr[slot];
						nibIdx[slot] <= {startAddr[slot], 1'b0};
						fetch[slot]  <= 1'b0;
						state        <= SEQ_ADDR;
					end
				end
				SEQ_ADDR: state <= SEQ_READ;   // ROM latency
				SEQ_READ: begin
					if (slotLive) begin
						if (inRange) begin
							nib.valid    <= 1'b1;
							nib.voice    <= slot;
							nib.nibble   <= nibIdx[slot][0] ? romData[3:0] : romData[7:4];
							nib.restart  <= (nibIdx[slot] == {startAddr[slot], 1'b0});
							nibIdx[slot] <= nibIdx[slot] + 1'b1;
						end else begin
							gate[slot] <= 1'b0;   // phrase finished
						end
					end
					state <= SEQ_NEXT;
				end
				SEQ_NEXT: begin
					if (slot == voiceId_t'(NUM_VOICES - 1)) begin
						state <= SEQ_WAIT;
					end else begin
						slot  <= slot + 1'b1;
						state <= SEQ_SLOT;
					end
				end
				default: state <= SEQ_WAIT;
			endcase

			// CPU commands override the round
			for (int v = 0; v < NUM_VOICES; v++) begin
				if (cmd.stopMask[v]) begin
					gate[v]    <= 1'b0;
					pending[v] <= 1'b0;
				end
			end
			if (cmd.startValid) begin
				gate[cmd.startVoice]    <= 1'b1;
				pending[cmd.startVoice] <= 1'b1;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (state == SEQ_HDR) begin
			case (hdrCnt)
				3'd1: startAddr[slot][17:16] <= romData[1:0];
				3'd2: startAddr[slot][15:8]  <= romData;
				3'd3: startAddr[slot][7:0]   <= romData;
				3'd4: endAddr[slot][17:16]   <= romData[1:0];
				3'd5: endAddr[slot][15:8]    <= romData;
				3'd6: endAddr[slot][7:0]     <= romData;
				default: ;
			endcase
		end
		if (cmd.startValid) begin
			phrase[cmd.startVoice] <= cmd.startPhrase;
			atten[cmd.startVoice]  <= cmd.startAtten;
		end
	end

endmodule

/* src/adpcmDecoder.sv */
// ============================================================
// ADPCM decoder
// per-voice signal and step index, clamped on every nibble
// ============================================================

`timescale 1ns/1ps

module adpcmDecoder import okiPkg::*; (
	input  logic    CLK,
	input  logic    RESET_N,
	nibbleIf.sink   nib,
	output signal_t signals [NUM_VOICES]
);

	stepIdx_t          stepIdx [NUM_VOICES];
	signal_t           curSig;
	stepIdx_t          curIdx;
	logic [10:0]       step;
	logic [11:0]       diff;
	logic signed [13:0] rawSig;
	logic signed [7:0] rawIdx;
	signal_t           nextSig;
	stepIdx_t          nextIdx;

	always_comb begin
		curSig = nib.restart ? signal_t'(0) : signals[nib.voice];
		curIdx = nib.restart ? stepIdx_t'(0) : stepIdx[nib.voice];
		step   = STEP_SIZE[curIdx];

		// step/8 + step/4 + step/2 + step, each floored
		diff = {1'b0, step >> 3};
		if (nib.nibble[0])
			diff = diff + (step >> 2);
		if (nib.nibble[1])
			diff = diff + (step >> 1);
		if (nib.nibble[2])
			diff = diff + step;

		if (nib.nibble[3])
			rawSig = $signed({{2{curSig[11]}}, curSig}) - $signed({2'b00, diff});
		else
			rawSig = $signed({{2{curSig[11]}}, curSig}) + $signed({2'b00, diff});

		if (rawSig > SIG_MAX)
			nextSig = signal_t'(SIG_MAX);
		else if (rawSig < SIG_MIN)
			nextSig = signal_t'(SIG_MIN);
		else
			nextSig = rawSig[11:0];

		rawIdx = $signed({2'b00, curIdx}) + STEP_ADJUST[nib.nibble[2:0]];
		if (rawIdx < 0)
			nextIdx = '0;
		else if (rawIdx > STEP_MAX)
			nextIdx = stepIdx_t'(STEP_MAX);
		else
			nextIdx = rawIdx[5:0];
	end

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			for (int v = 0; v < NUM_VOICES; v++) begin
				signals[v] <= '0;
				stepIdx[v] <= '0;
			end
		end else if (nib.valid) begin
			signals[nib.voice] <= nextSig;
			stepIdx[nib.voice] <= nextIdx;
		end
	end

endmodule

/* src/outputMixer.sv */
// ============================================================
// output mixer
// sample rate timer, per-voice volume and the four voice sum
// ============================================================

`timescale 1ns/1ps

module outputMixer import okiPkg::*; (
	input  logic                  CLK,
	input  logic                  RESET_N,
	input  logic                  ss,
	input  logic [NUM_VOICES-1:0] gates,
	input  atten_t                atten [NUM_VOICES],
	input  signal_t               signals [NUM_VOICES],
	output logic                  sampleTick,
	output mix_t                  soundOut,
	output logic                  sampleStrobe
);

	logic [9:0] rateCount;
	mix_t       mixSum;

	assign sampleTick = (rateCount == '0);

	always_comb begin
		logic signed [6:0] volume;
		sample_t           product;

		mixSum = '0;
		for (int v = 0; v < NUM_VOICES; v++) begin
			volume  = $signed({1'b0, VOLUME[atten[v]]});
			product = signals[v] * volume;
			if (gates[v])
				mixSum = mixSum + product;   // silent voices add nothing
		end
	end

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N) begin
			rateCount    <= RATE_SLOW;
			soundOut     <= '0;
			sampleStrobe <= 1'b0;
		end else begin
			sampleStrobe <= sampleTick;
			if (sampleTick) begin
				rateCount <= ss ? RATE_FAST : RATE_SLOW;
				soundOut  <= mixSum;
			end else begin
				rateCount <= rateCount - 1'b1;
			end
		end
	end

endmodule

/* src/oki6295.sv */
// ============================================================
// four voice OKI ADPCM sound generator, top level
// command decode, sequencing, decode and mix
// ============================================================

`timescale 1ns/1ps

module oki6295 import okiPkg::*; (
	input  logic                  CLK,
	input  logic                  RESET_N,
	input  logic                  chipSelN,
	input  logic                  writeN,
	input  romByte_t              dataIn,
	input  logic                  ss,          // sample rate select
	output romAddr_t              romAddr,
	input  romByte_t              romData,
	output mix_t                  soundOut,
	output logic                  sampleStrobe,
	output logic [NUM_VOICES-1:0] gateStatus
);

	cmdIf    cmdBus ();
	nibbleIf nibBus ();

	logic [NUM_VOICES-1:0] gates;
	atten_t                atten [NUM_VOICES];
	signal_t               signals [NUM_VOICES];
	logic                  sampleTick;

	assign gateStatus = gates;

	cmdDecoder uCmd (
		.CLK      (CLK),
		.RESET_N  (RESET_N),
		.chipSelN (chipSelN),
		.writeN   (writeN),
		.dataIn   (dataIn),
		.cmd      (cmdBus.source)
	);

	voiceSequencer uSeq (
		.CLK        (CLK),
		.RESET_N    (RESET_N),
		.cmd        (cmdBus.sink),
		.sampleTick (sampleTick),
		.romAddr    (romAddr),
		.romData    (romData),
		.nib        (nibBus.source),
		.gates      (gates),
		.atten      (atten)
	);

	adpcmDecoder uDec (
		.CLK     (CLK),
		.RESET_N (RESET_N),
		.nib     (nibBus.sink),
		.signals (signals)
	);

	outputMixer uMix (
		.CLK          (CLK),
		.RESET_N      (RESET_N),
		.ss           (ss),
		.gates        (gates),
		.atten        (atten),
		.signals      (signals),
		.sampleTick   (sampleTick),
		.soundOut     (soundOut),
		.sampleStrobe (sampleStrobe)
	);

endmodule

/* bench/oki6295_properties.sv */
// ============================================================
// sequencer assertions
// nibbles only in a round, one per voice per round and no
// gate rising without a start
// ============================================================

`timescale 1ns/1ps

module oki6295_properties import okiPkg::*; (
	input logic                  CLK,
	input logic                  RESET_N,
	input logic                  sampleTick,
	input seqState_t             state,
	input logic                  nibValid,
	input voiceId_t              nibVoice,
	input logic [NUM_VOICES-1:0] gate,
	input logic                  startValid,
	input voiceId_t              startVoice
);

	logic [NUM_VOICES-1:0] emitted;   // voices that sent a nibble since the tick

	always_ff @(posedge CLK or negedge RESET_N) begin
		if (!RESET_N)
			emitted <= '0;
		else if (sampleTick)
			emitted <= '0;
		else if (nibValid)
			emitted[nibVoice] <= 1'b1;
	end

	assert property (@(posedge CLK) disable iff (!RESET_N) nibValid |-> state != SEQ_WAIT)
		else $error("nibble outside a sample round");

	assert property (@(posedge CLK) disable iff (!RESET_N) nibValid |-> !emitted[nibVoice])
		else $error("voice emitted two nibbles in one round");

	for (genvar i = 0; i < NUM_VOICES; i++) begin : gateRise
		assert property (@(posedge CLK) disable iff (!RESET_N)
			(!gate[i] && !(startValid && startVoice == voiceId_t'(i))) |=> !gate[i])
			else $error("gate %0d rose without a start", i);
	end

endmodule

/* bench/oki6295Tb.sv */
// ============================================================
// testbench for the four voice OKI ADPCM generator
// random commands against a reference model, ROM model and
// per-strobe checks of soundOut and the gate status
// ============================================================

`timescale 1ns/1ps

module oki6295Tb import okiPkg::*; ();

	localparam int PLANNED = 6 + 64 + 4 + 7 + 56 + 200;   // strobes per phase
	localparam int LIMIT   = 600 * PLANNED + 100;

	localparam int STEP_TAB [0:48] = '{
		16, 17, 19, 21, 23, 25, 28, 31, 34, 37, 41, 45, 50, 55, 60, 66, 73,
		80, 88, 97, 107, 118, 130, 143, 157, 173, 190, 209, 230, 253, 279,
		307, 337, 371, 408, 449, 494, 544, 598, 658, 724, 796, 876, 963,
		1060, 1166, 1282, 1411, 1552
	};
	localparam int ADJ_TAB [0:7]  = '{-1, -1, -1, -1, 2, 4, 6, 8};
	localparam int VOL_TAB [0:15] = '{32, 22, 16, 11, 8, 6, 4, 3, 2, 0, 0, 0, 0, 0, 0, 0};

	logic       CLK;
	logic       RESET_N;
	logic       chipSelN;
	logic       writeN;
	romByte_t   dataIn;
	logic       ss;
	romAddr_t   romAddr;
	romByte_t   romData;
	mix_t       soundOut;
	logic       sampleStrobe;
	logic [3:0] gateStatus;

	romByte_t   rom [0:(1 << 18) - 1];
	logic [3:0] mGate;
	logic [3:0] mPend;   // started, not yet admitted
	int         mSig [4];
	int         mIdx [4];
	int         mAtt [4];
	int         mStart [4];
	int         mEnd [4];
	int         mNib [4];   // byte address times two plus nibble select
	int         cycles = 0;
	int         t0;

	oki6295 DUT (
		.CLK          (CLK),
		.RESET_N      (RESET_N),
		.chipSelN     (chipSelN),
		.writeN       (writeN),
		.dataIn       (dataIn),
		.ss           (ss),
		.romAddr      (romAddr),
		.romData      (romData),
		.soundOut     (soundOut),
		.sampleStrobe (sampleStrobe),
		.gateStatus   (gateStatus)
	);

	bind voiceSequencer oki6295_properties seqProps (
		.CLK(CLK), .RESET_N(RESET_N), .sampleTick(sampleTick), .state(state),
		.nibValid(nib.valid), .nibVoice(nib.voice), .gate(gate),
		.startValid(cmd.startValid), .startVoice(cmd.startVoice)
	);

	always #10 CLK = ~CLK;

	always @(posedge CLK) romData <= rom[romAddr];   // one cycle ROM

	always @(posedge CLK) begin
		cycles++;
		if (cycles > LIMIT) begin
			$display("timeout: the run took more than %0d cycles", LIMIT);
			$display("Test failures found");
			$fatal(1, "timeout");
		end
	end

	task automatic checkMix(input mix_t got, input mix_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s soundOut %0d expected %0d", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "soundOut mismatch");
		end
	endtask

	task automatic checkGates(input logic [3:0] got, input logic [3:0] exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s gateStatus %b expected %b", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "gate mismatch");
		end
	endtask

	task automatic checkAddr(input romAddr_t got, input romAddr_t exp, input string what);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t ns: %s romAddr %h expected %h", $time, what, got, exp);
			$display("Test failures found");
			$fatal(1, "romAddr mismatch");
		end
	endtask

	task automatic checkPeriod(input int got, input int exp);
		if (got != exp) begin
			$display("CHECK FAILED at %0t ns: strobe period %0d expected %0d", $time, got, exp);
			$display("Test failures found");
			$fatal(1, "period mismatch");
		end
	endtask

	function automatic int hdrAddr(input int p, input int off);
		return {rom[p * 8 + off][1:0], rom[p * 8 + off + 1], rom[p * 8 + off + 2]};
	endfunction

	function automatic void decodeNibble(input int v, input logic [3:0] n);
		int step;
		int diff;
		step = STEP_TAB[mIdx[v]];
		diff = step / 8;
		if (n[0]) diff += step / 4;
		if (n[1]) diff += step / 2;
		if (n[2]) diff += step;
		mSig[v] = n[3] ? mSig[v] - diff : mSig[v] + diff;
		if (mSig[v] > 2047) mSig[v] = 2047;
		if (mSig[v] < -2048) mSig[v] = -2048;
		mIdx[v] = mIdx[v] + ADJ_TAB[n[2:0]];
		if (mIdx[v] < 0) mIdx[v] = 0;
		if (mIdx[v] > 48) mIdx[v] = 48;
	endfunction

	// one sample round of the model
	function automatic void runRound();
		int a;
		logic [3:0] n;
		for (int v = 0; v < 4; v++) begin
			if (mPend[v]) begin
				mPend[v] = 1'b0;
				mNib[v]  = mStart[v] * 2;
			end
		end
		for (int v = 0; v < 4; v++) begin
			if (mGate[v]) begin
				a = mNib[v] / 2;
				if (a >= 'h400 && a >= mStart[v] && a <= mEnd[v]) begin
					n = mNib[v][0] ? rom[a][3:0] : rom[a][7:4];   // high nibble first
					if (mNib[v] == mStart[v] * 2) begin
						mSig[v] = 0;
						mIdx[v] = 0;
					end
					decodeNibble(v, n);
					mNib[v]++;
				end else begin
					mGate[v] = 1'b0;
				end
			end
		end
	endfunction

	function automatic mix_t expectedMix();
		int sum;
		sum = 0;
		for (int v = 0; v < 4; v++)
			if (mGate[v]) sum += mSig[v] * VOL_TAB[mAtt[v]];
		return mix_t'(sum);
	endfunction

	task automatic nextStrobe(input string what);
		do @(negedge CLK); while (!sampleStrobe);
		checkMix(soundOut, expectedMix(), what);
		checkGates(gateStatus, mGate, what);
		runRound();
	endtask

	// commands go in after the round has finished
	task automatic quietWait();
		repeat (64) @(negedge CLK);
	endtask

	task automatic writeByte(input romByte_t b);
		chipSelN = 1'b0;
		writeN   = 1'b0;
		dataIn   = b;
		repeat (2) @(negedge CLK);
		writeN   = 1'b1;
		chipSelN = 1'b1;
		@(negedge CLK);
	endtask

	task automatic sendStart(input int p, input romByte_t second);
		int v;
		v = -1;
		writeByte(romByte_t'(8'h80 | p));
		writeByte(second);
		for (int i = 3; i >= 0; i--)
			if (second[4 + i]) v = i;   // lowest voice bit wins
		if (v >= 0) begin
			mGate[v]  = 1'b1;
			mPend[v]  = 1'b1;
			mAtt[v]   = second[3:0];
			mStart[v] = hdrAddr(p, 0);
			mEnd[v]   = hdrAddr(p, 3);
		end
		checkGates(gateStatus, mGate, "start command");
	endtask

	task automatic sendStop(input logic [3:0] mask);
		writeByte({1'b0, mask, 3'b000});
		mGate &= ~mask;
		mPend &= ~mask;
		checkGates(gateStatus, mGate, "stop command");
	endtask

	function automatic romByte_t voiceByte(input int v, input int att);
		return romByte_t'((1 << (4 + v)) | att);
	endfunction

	initial begin
		romAddr_t s;
		romAddr_t e;
		CLK      = 0;
		RESET_N  = 0;
		chipSelN = 1;
		writeN   = 1;
		dataIn   = '0;
		ss       = 0;
		romData  = '0;
		void'($urandom(32'h89f248bb));
		for (int a = 0; a < (1 << 18); a++)
			rom[a] = romByte_t'($urandom);
		// 16 phrase headers pointing at short data regions
		for (int p = 0; p < 16; p++) begin
			s = romAddr_t'('h400 + p * 32 + $urandom % 8);
			e = romAddr_t'(s + 8 + $urandom % 17 - 1);
			rom[p * 8]     = {6'd0, s[17:16]};
			rom[p * 8 + 1] = s[15:8];
			rom[p * 8 + 2] = s[7:0];
			rom[p * 8 + 3] = {6'd0, e[17:16]};
			rom[p * 8 + 4] = e[15:8];
			rom[p * 8 + 5] = e[7:0];
		end
		mGate = '0;
		mPend = '0;
		for (int v = 0; v < 4; v++) begin
			mSig[v]   = 0;
			mIdx[v]   = 0;
			mAtt[v]   = 0;
			mStart[v] = 0;
			mEnd[v]   = 0;
			mNib[v]   = 0;
		end
		repeat (8) @(posedge CLK);
		@(negedge CLK);
		RESET_N = 1'b1;
		checkMix(soundOut, mix_t'(0), "after reset");
		checkGates(gateStatus, 4'h0, "after reset");
		checkAddr(romAddr, romAddr_t'(0), "after reset");

		nextStrobe("idle");
		t0 = cycles;
		nextStrobe("idle");
		checkPeriod(cycles - t0, 493);
		ss = 1'b1;
		nextStrobe("idle");   // reload already taken with ss low
		t0 = cycles;
		nextStrobe("idle");
		checkPeriod(cycles - t0, 394);
		ss = 1'b0;
		nextStrobe("idle");
		nextStrobe("idle");

		for (int att = 0; att < 16; att++) begin
			quietWait();
			sendStart($urandom % 16, voiceByte($urandom % 4, att));
			repeat (3) nextStrobe("single voice");
			quietWait();
			sendStop(4'hf);
			nextStrobe("single voice off");
		end

		quietWait();
		sendStart(3, 8'he5);   // voices 2..4 named, voice 2 starts
		sendStart(4, 8'h07);   // no voice bit
		sendStart(5, 8'h9a);
		repeat (3) nextStrobe("voice pick");
		quietWait();
		sendStop(4'hf);
		nextStrobe("voice pick off");

		quietWait();
		for (int v = 0; v < 4; v++)
			sendStart($urandom % 16, voiceByte(v, $urandom % 9));
		repeat (3) nextStrobe("four voices");
		quietWait();
		sendStop(4'b0101);
		repeat (3) nextStrobe("partial stop");
		quietWait();
		sendStop(4'hf);
		nextStrobe("all stopped");

		quietWait();
		sendStart($urandom % 16, voiceByte(2, 1));
		repeat (56) nextStrobe("end of phrase");
		checkGates(gateStatus, 4'h0, "phrase ended by itself");

		quietWait();
		for (int v = 0; v < 4; v++)
			sendStart($urandom % 16, voiceByte(v, $urandom % 16));
		for (int k = 0; k < 200; k++) begin
			nextStrobe("mix");
			if ($urandom % 3 == 0) begin
				quietWait();
				sendStart($urandom % 16, voiceByte($urandom % 4, $urandom % 16));
			end
		end

		$display("All tests passed!");
		$finish;
	end

endmodule

/* flist.f */
src/okiPkg.sv
src/cmdIf.sv
src/nibbleIf.sv
src/cmdDecoder.sv
src/voiceSequencer.sv
src/adpcmDecoder.sv
src/outputMixer.sv
src/oki6295.sv
bench/oki6295_properties.sv
bench/oki6295Tb.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = oki6295Tb
FLIST     = flist.f
OBJDIR    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
